/* hdl/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  strobe_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {SRC_B_RT, SRC_B_SIMM, SRC_B_ZIMM, SRC_B_LUI} src_b_e;
    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_LINK} wb_sel_e;
    typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE, BR_J} branch_e;
    typedef enum logic [1:0] {FWD_RF, FWD_EXE, FWD_MEM, FWD_WB} fwd_e;

    // all-zero value is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        src_b_e  src_b;
        wb_sel_e wb_sel;
        logic    mem_write;
        logic    reg_write;
    } ctrl_t;

    typedef struct packed {logic valid; addr_t addr;} ibus_req_t;
    typedef struct packed {logic data_ok; word_t data;} ibus_resp_t;
    typedef struct packed {logic valid; addr_t addr; strobe_t strobe; word_t data;} dbus_req_t;
    typedef struct packed {logic data_ok; word_t data;} dbus_resp_t;

    typedef struct packed {logic valid; word_t instr; addr_t pc;} fetch_out_t;
    typedef struct packed {logic taken; addr_t target;} redirect_t;

    typedef struct packed {
        ctrl_t       ctrl;
        word_t       src_a;
        word_t       src_b;
        logic [15:0] imm;
        logic [4:0]  shamt;
        reg_idx_t    dst;
        addr_t       pc_plus8;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t dst;
        addr_t    pc_plus8;
    } ex_mem_t;

    typedef struct packed {logic reg_write; logic is_load; reg_idx_t dst; word_t result;} stage_dst_t;
    typedef struct packed {logic en; reg_idx_t idx; word_t data;} reg_write_t;
    typedef struct packed {reg_idx_t rs; reg_idx_t rt;} src_regs_t;
    typedef struct packed {fwd_e a; fwd_e b;} fwd_sel_t;

    typedef struct packed {
        logic stall_f;
        logic stall_d;
        logic stall_em;
        logic flush_e;
        logic flush_w;
    } pipe_ctrl_t;

    // producer view of a stage where jal reports its link value
    function automatic stage_dst_t stage_summary(ctrl_t c, reg_idx_t dst, word_t alu_result,
                                                 addr_t pc_plus8);
        stage_dst_t s;
        s.reg_write = c.reg_write;
        s.is_load   = (c.wb_sel == WB_MEM);
        s.dst       = dst;
        s.result    = (c.wb_sel == WB_LINK) ? pc_plus8 : alu_result;
        return s;
    endfunction

endpackage

/* hdl/core_top.sv */
module core_top #(
    parameter core_pkg::addr_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                 clk,
    input  logic                 resetn,
    output core_pkg::ibus_req_t  ireq,
    input  core_pkg::ibus_resp_t iresp,
    output core_pkg::dbus_req_t  dreq,
    input  core_pkg::dbus_resp_t dresp
);
    import core_pkg::*;

    pipe_ctrl_t pipe_ctrl;
    fetch_out_t fetched;
    redirect_t  redirect;
    src_regs_t  srcs;
    fwd_sel_t   fwd;
    id_ex_t     id_ex;
    ex_mem_t    ex_mem;
    stage_dst_t exe_dst;
    stage_dst_t mem_dst;
    reg_write_t wb_write;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk,
        .resetn,
        .ctrl(pipe_ctrl),
        .redirect,
        .ireq,
        .iresp,
        .fetched
    );

    decode_stage u_decode (
        .clk,
        .resetn,
        .ctrl(pipe_ctrl),
        .fetched,
        .fwd,
        .exe_dst,
        .mem_dst,
        .wb_write,
        .srcs,
        .redirect,
        .id_ex
    );

    execute_stage u_execute (
        .clk,
        .resetn,
        .ctrl(pipe_ctrl),
        .id_ex,
        .ex_mem,
        .exe_dst
    );

    memory_writeback u_mem_wb (
        .clk,
        .resetn,
        .ctrl(pipe_ctrl),
        .ex_mem,
        .dreq,
        .dresp,
        .mem_dst,
        .wb_write
    );

    hazard_unit u_hazard (
        .fetched_valid(fetched.valid),
        .srcs,
        .exe_dst,
        .mem_dst,
        .wb_write,
        .dbus_wait(dreq.valid && !dresp.data_ok),
        .ctrl(pipe_ctrl),
        .fwd
    );

endmodule

/* hdl/decode_stage.sv */
module decode_stage (
    input  logic                 clk,
    input  logic                 resetn,
    input  core_pkg::pipe_ctrl_t ctrl,
    input  core_pkg::fetch_out_t fetched,
    input  core_pkg::fwd_sel_t   fwd,
    input  core_pkg::stage_dst_t exe_dst,
    input  core_pkg::stage_dst_t mem_dst,
    input  core_pkg::reg_write_t wb_write,
    output core_pkg::src_regs_t  srcs,
    output core_pkg::redirect_t  redirect,
    output core_pkg::id_ex_t     id_ex
);
    import core_pkg::*;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    fetch_out_t  dec_q;
    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    reg_idx_t    dst;
    ctrl_t       dec_ctrl;
    branch_e     branch;
    word_t       rf_a;
    word_t       rf_b;
    word_t       opa;
    word_t       opb;
    addr_t       pc_plus4;
    addr_t       br_target;

    function automatic ctrl_t imm_op(alu_op_e op, src_b_e sb);
        return '{alu_op: op, src_b: sb, wb_sel: WB_ALU, mem_write: 1'b0, reg_write: 1'b1};
    endfunction

    function automatic word_t pick_operand(fwd_e sel, word_t rf_val, word_t exe_val,
                                           word_t mem_val, word_t wb_val);
        case (sel)
            FWD_EXE: return exe_val;
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dec_q <= '0;
        end else if (!ctrl.stall_d) begin
            dec_q <= fetched;
        end
    end

    assign opcode = dec_q.instr[31:26];
    assign rs     = dec_q.instr[25:21];
    assign rt     = dec_q.instr[20:16];
    assign rd     = dec_q.instr[15:11];
    assign funct  = dec_q.instr[5:0];
    assign srcs   = '{rs: rs, rt: rt};

    always_comb begin
        dec_ctrl = '0;
        branch   = BR_NONE;
        dst      = rt;
        if (dec_q.valid) begin
            case (opcode)
                OP_SPECIAL: begin
                    dst = rd;
                    dec_ctrl = imm_op(ALU_ADD, SRC_B_RT);
                    case (funct)
                        FN_SLL:  dec_ctrl.alu_op = ALU_SLL;
                        FN_SRL:  dec_ctrl.alu_op = ALU_SRL;
                        FN_SRA:  dec_ctrl.alu_op = ALU_SRA;
                        FN_ADDU: dec_ctrl.alu_op = ALU_ADD;
                        FN_SUBU: dec_ctrl.alu_op = ALU_SUB;
                        FN_AND:  dec_ctrl.alu_op = ALU_AND;
                        FN_OR:   dec_ctrl.alu_op = ALU_OR;
                        FN_XOR:  dec_ctrl.alu_op = ALU_XOR;
                        FN_NOR:  dec_ctrl.alu_op = ALU_NOR;
                        FN_SLT:  dec_ctrl.alu_op = ALU_SLT;
                        FN_SLTU: dec_ctrl.alu_op = ALU_SLTU;
                        default: dec_ctrl = '0;
                    endcase
                end
                OP_ADDIU: dec_ctrl = imm_op(ALU_ADD, SRC_B_SIMM);
                OP_SLTI:  dec_ctrl = imm_op(ALU_SLT, SRC_B_SIMM);
                OP_ANDI:  dec_ctrl = imm_op(ALU_AND, SRC_B_ZIMM);
                OP_ORI:   dec_ctrl = imm_op(ALU_OR, SRC_B_ZIMM);
                OP_XORI:  dec_ctrl = imm_op(ALU_XOR, SRC_B_ZIMM);
                // rs is zero in a lui encoding
                OP_LUI:   dec_ctrl = imm_op(ALU_OR, SRC_B_LUI);
                OP_LW: begin
                    dec_ctrl = imm_op(ALU_ADD, SRC_B_SIMM);
                    dec_ctrl.wb_sel = WB_MEM;
                end
                OP_SW: begin
                    dec_ctrl = imm_op(ALU_ADD, SRC_B_SIMM);
                    dec_ctrl.wb_sel = WB_NONE;
                    dec_ctrl.reg_write = 1'b0;
                    dec_ctrl.mem_write = 1'b1;
                end
                OP_BEQ: branch = BR_BEQ;
                OP_BNE: branch = BR_BNE;
                OP_J:   branch = BR_J;
                OP_JAL: begin
                    branch = BR_J;
                    dst = 5'd31;
                    dec_ctrl = imm_op(ALU_ADD, SRC_B_RT);
                    dec_ctrl.wb_sel = WB_LINK;
                end
                default: dec_ctrl = '0;
            endcase
        end
    end

    reg_file u_regs (
        .clk,
        .ra1(rs),
        .ra2(rt),
        .rd1(rf_a),
        .rd2(rf_b),
        .wr(wb_write)
    );

    always_comb begin
        opa = pick_operand(fwd.a, rf_a, exe_dst.result, mem_dst.result, wb_write.data);
        opb = pick_operand(fwd.b, rf_b, exe_dst.result, mem_dst.result, wb_write.data);
    end

    assign pc_plus4  = dec_q.pc + 32'd4;
    assign br_target = pc_plus4 + {{14{dec_q.instr[15]}}, dec_q.instr[15:0], 2'b00};

    always_comb begin
        redirect = '{taken: 1'b0, target: br_target};
        case (branch)
            BR_BEQ: redirect.taken = (opa == opb);
            BR_BNE: redirect.taken = (opa != opb);
            BR_J:   redirect = '{taken: 1'b1, target: {pc_plus4[31:28], dec_q.instr[25:0], 2'b00}};
            default: redirect.taken = 1'b0;
        endcase
    end

    // flush_e never comes while execute is held
    always_ff @(posedge clk) begin
        if (!resetn || ctrl.flush_e) begin
            id_ex <= '0;
        end else if (!ctrl.stall_em) begin
            id_ex <= '{
                ctrl:     dec_ctrl,
                src_a:    opa,
                src_b:    opb,
                imm:      dec_q.instr[15:0],
                shamt:    dec_q.instr[10:6],
                dst:      dst,
                pc_plus8: dec_q.pc + 32'd8
            };
        end
    end

endmodule

/* hdl/execute_stage.sv */
module execute_stage (
    input  logic                 clk,
    input  logic                 resetn,
    input  core_pkg::pipe_ctrl_t ctrl,
    input  core_pkg::id_ex_t     id_ex,
    output core_pkg::ex_mem_t    ex_mem,
    output core_pkg::stage_dst_t exe_dst
);
    import core_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_out;

    assign op_a = id_ex.src_a;

    always_comb begin
        case (id_ex.ctrl.src_b)
            SRC_B_SIMM: op_b = {{16{id_ex.imm[15]}}, id_ex.imm};
            SRC_B_ZIMM: op_b = {16'h0000, id_ex.imm};
            SRC_B_LUI:  op_b = {id_ex.imm, 16'h0000};
            default:    op_b = id_ex.src_b;
        endcase
    end

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_NOR:  alu_out = ~(op_a | op_b);
            ALU_SLT:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {31'd0, op_a < op_b};
            // shifts take rt and the shamt field
            ALU_SLL:  alu_out = op_b << id_ex.shamt;
            ALU_SRL:  alu_out = op_b >> id_ex.shamt;
            ALU_SRA:  alu_out = word_t'($signed(op_b) >>> id_ex.shamt);
            default:  alu_out = op_a + op_b;
        endcase
    end

    assign exe_dst = stage_summary(id_ex.ctrl, id_ex.dst, alu_out, id_ex.pc_plus8);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_mem <= '0;
        end else if (!ctrl.stall_em) begin
            ex_mem <= '{
                ctrl:       id_ex.ctrl,
                alu_result: alu_out,
                store_data: id_ex.src_b,
                dst:        id_ex.dst,
                pc_plus8:   id_ex.pc_plus8
            };
        end
    end

endmodule

/* hdl/fetch_stage.sv */
module fetch_stage #(
    parameter core_pkg::addr_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  core_pkg::pipe_ctrl_t ctrl,
    input  core_pkg::redirect_t  redirect,
    output core_pkg::ibus_req_t  ireq,
    input  core_pkg::ibus_resp_t iresp,
    output core_pkg::fetch_out_t fetched
);
    import core_pkg::*;

    addr_t pc;
    logic  running;
    logic  hold_valid;
    word_t hold_instr;
    logic  word_ok;

    // no new request while a returned word waits for decode
    assign ireq = '{valid: running && !hold_valid, addr: pc};

    assign word_ok = ireq.valid && iresp.data_ok;

    assign fetched = '{
        valid: hold_valid || word_ok,
        instr: hold_valid ? hold_instr : iresp.data,
        pc:    pc
    };

    always_ff @(posedge clk) begin
        if (!resetn) begin
            running    <= 1'b0;
            hold_valid <= 1'b0;
            pc         <= RESET_PC;
        end else begin
            running <= 1'b1;
            // the branch held in decode picks the pc after the taken word
            if (fetched.valid && !ctrl.stall_f) begin
                pc <= redirect.taken ? redirect.target : pc + 32'd4;
            end
            if (!ctrl.stall_d) begin
                hold_valid <= 1'b0;
            end else if (word_ok) begin
                hold_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_ok && ctrl.stall_d) begin
            hold_instr <= iresp.data;
        end
    end

endmodule

/* hdl/hazard_unit.sv */
module hazard_unit (
    input  logic                 fetched_valid,
    input  core_pkg::src_regs_t  srcs,
    input  core_pkg::stage_dst_t exe_dst,
    input  core_pkg::stage_dst_t mem_dst,
    input  core_pkg::reg_write_t wb_write,
    input  logic                 dbus_wait,
    output core_pkg::pipe_ctrl_t ctrl,
    output core_pkg::fwd_sel_t   fwd
);
    import core_pkg::*;

    logic exe_load_hit;
    logic mem_load_hit;
    logic load_use;

    function automatic logic hits(stage_dst_t p, reg_idx_t r);
        return p.reg_write && (r != '0) && (p.dst == r);
    endfunction

    function automatic fwd_e fwd_for(reg_idx_t r, stage_dst_t exe, stage_dst_t mem,
                                     reg_write_t wb);
        if (hits(exe, r)) begin
            return FWD_EXE;
        end else if (hits(mem, r)) begin
            return FWD_MEM;
        end else if (wb.en && (r != '0) && (wb.idx == r)) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    // load data reaches decode only from writeback
    assign exe_load_hit = exe_dst.is_load && (hits(exe_dst, srcs.rs) || hits(exe_dst, srcs.rt));
    assign mem_load_hit = mem_dst.is_load && (hits(mem_dst, srcs.rs) || hits(mem_dst, srcs.rt));
    assign load_use     = exe_load_hit || mem_load_hit;

    assign ctrl = '{
        stall_f:  load_use || dbus_wait,
        stall_d:  load_use || !fetched_valid || dbus_wait,
        stall_em: dbus_wait,
        flush_e:  (load_use || !fetched_valid) && !dbus_wait,
        flush_w:  dbus_wait
    };

    always_comb begin
        fwd.a = fwd_for(srcs.rs, exe_dst, mem_dst, wb_write);
        fwd.b = fwd_for(srcs.rt, exe_dst, mem_dst, wb_write);
    end

endmodule

/* hdl/memory_writeback.sv */
module memory_writeback (
    input  logic                 clk,
    input  logic                 resetn,
    input  core_pkg::pipe_ctrl_t ctrl,
    input  core_pkg::ex_mem_t    ex_mem,
    output core_pkg::dbus_req_t  dreq,
    input  core_pkg::dbus_resp_t dresp,
    output core_pkg::stage_dst_t mem_dst,
    output core_pkg::reg_write_t wb_write
);
    import core_pkg::*;

    ex_mem_t wb_q;
    word_t   load_q;

    // word accesses only with the address straight from the alu
    assign dreq = '{
        valid:  ex_mem.ctrl.mem_write || (ex_mem.ctrl.wb_sel == WB_MEM),
        addr:   ex_mem.alu_result,
        strobe: ex_mem.ctrl.mem_write ? 4'b1111 : 4'b0000,
        data:   ex_mem.store_data
    };

    assign mem_dst = stage_summary(ex_mem.ctrl, ex_mem.dst, ex_mem.alu_result, ex_mem.pc_plus8);

    // bubble while the data bus is still busy
    always_ff @(posedge clk) begin
        if (!resetn || ctrl.flush_w) begin
            wb_q <= '0;
        end else begin
            wb_q <= ex_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (dresp.data_ok) begin
            load_q <= dresp.data;
        end
    end

    always_comb begin
        wb_write.en  = wb_q.ctrl.reg_write;
        wb_write.idx = wb_q.dst;
        case (wb_q.ctrl.wb_sel)
            WB_MEM:  wb_write.data = load_q;
            WB_LINK: wb_write.data = wb_q.pc_plus8;
            default: wb_write.data = wb_q.alu_result;
        endcase
    end

endmodule

/* hdl/reg_file.sv */
module reg_file (
    input  logic                 clk,
    input  core_pkg::reg_idx_t   ra1,
    input  core_pkg::reg_idx_t   ra2,
    output core_pkg::word_t      rd1,
    output core_pkg::word_t      rd2,
    input  core_pkg::reg_write_t wr
);
    import core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            regs[wr.idx] <= wr.data;
        end
    end

    // $0 reads zero whatever was written
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

/* sim.f */
hdl/core_pkg.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_writeback.sv
hdl/hazard_unit.sv
hdl/core_top.sv
tests/core_assert.sv
tests/core_tb.sv

/* tests/core_assert.sv */
module core_assert (
    input logic                 clk,
    input logic                 resetn,
    input core_pkg::ibus_req_t  ireq,
    input core_pkg::ibus_resp_t iresp,
    input core_pkg::dbus_req_t  dreq,
    input core_pkg::dbus_resp_t dresp,
    input core_pkg::ex_mem_t    ex_mem
);
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    // request held until data_ok
    ibus_stable: assert property (@(posedge clk) disable iff (!resetn)
        ireq.valid && !iresp.data_ok |=> ireq.valid && $stable(ireq.addr))
        else $error("instruction request changed before data_ok");

    dbus_stable: assert property (@(posedge clk) disable iff (!resetn)
        dreq.valid && !dresp.data_ok |=> dreq.valid && $stable(dreq))
        else $error("data request changed before data_ok");

    idle_in_reset: assert property (@(posedge clk)
        !resetn |=> !ireq.valid && !dreq.valid)
        else $error("bus request valid during reset");

    // a load enables no bytes and a store enables all four
    strobe_rule: assert property (@(posedge clk) disable iff (!resetn)
        dreq.valid |-> dreq.strobe == ((ex_mem.ctrl.wb_sel == WB_MEM) ? 4'h0 : 4'hf))
        else $error("data request strobe does not match the access direction");

endmodule

bind core_top core_assert u_assert (.*);

/* tests/core_tb.sv */
module core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    localparam addr_t RESET_PC = 32'hbfc0_0000;
    localparam int PRO = 31;
    localparam int DUMP = PRO + 48;
    localparam int LOOP = DUMP + 31;

    logic       clk;
    logic       resetn;
    ibus_req_t  ireq;
    ibus_resp_t iresp;
    dbus_req_t  dreq;
    dbus_resp_t dresp;

    logic [31:0] lfsr;
    word_t       prog [128];
    word_t       dmem [64];
    word_t       m_mem [64];
    word_t       m_regs [32];
    addr_t       exp_pc [$];
    addr_t       got_pc [$];
    dbus_req_t   exp_acc [$];
    dbus_req_t   got_acc [$];
    int          errors;
    int          timeouts;
    int          i_left;
    int          d_left;

    core_top #(.RESET_PC(RESET_PC)) UUT (.clk, .resetn, .ireq, .iresp, .dreq, .dresp);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic is_transfer(word_t w);
        return w[31:26] inside {6'h02, 6'h03, 6'h04, 6'h05};
    endfunction

    function automatic word_t body_instr(int idx, logic may_branch);
        logic [3:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic [5:0]  fn;
        int          off;
        addr_t       tgt;
        kind = rand_bits(4);
        rs = rand_bits(5);
        rt = rand_bits(5);
        rd = rand_bits(5);
        sh = rand_bits(5);
        imm = rand_bits(16);
        if (kind == 4'd15 && !may_branch) begin
            kind = 4'd9;
        end
        case (kind)
            4'd0: fn = 6'h21;
            4'd1: fn = 6'h23;
            4'd2: fn = 6'h24;
            4'd3: fn = 6'h25;
            4'd4: fn = 6'h26;
            4'd5: fn = 6'h27;
            4'd6: fn = 6'h2a;
            4'd7: fn = 6'h2b;
            default: fn = 6'h00;
        endcase
        case (kind)
            4'd8: begin
                off = rand_bits(2) % 3;
                return {6'h00, 5'd0, rt, rd, sh, (off == 0) ? 6'h00 : 6'(off + 1)};
            end
            4'd9:  return {6'h09, rs, rt, imm};
            4'd10: return {6'h0c + 6'(rand_bits(2) % 3), rs, rt, imm};
            4'd11: return {6'h0a, rs, rt, imm};
            4'd12: return {6'h0f, 5'd0, rt, imm};
            4'd13: return {6'h23, 5'd0, rt, 8'h00, imm[5:0], 2'b00};
            4'd14: return {6'h2b, 5'd0, rt, 8'h00, imm[5:0], 2'b00};
            4'd15: begin
                off = 1 + rand_bits(2);
                if (idx + 1 + off > DUMP) begin
                    off = DUMP - idx - 1;
                end
                tgt = RESET_PC + 4 * (idx + 1 + off);
                case (rand_bits(2))
                    2'd0: return {6'h04, rs, rt, 16'(off)};
                    2'd1: return {6'h05, rs, rt, 16'(off)};
                    2'd2: return {6'h02, tgt[27:2]};
                    default: return {6'h03, tgt[27:2]};
                endcase
            end
            default: return {6'h00, rs, rt, rd, 5'd0, fn};
        endcase
    endfunction

    // instruction-set model with delay slots
    task automatic run_model();
        addr_t pc;
        addr_t npc;
        addr_t nxt;
        addr_t ea;
        word_t ins;
        word_t a;
        word_t b;
        word_t res;
        word_t simm;
        logic  wr;
        reg_idx_t d;
        for (int k = 0; k < 32; k++) begin
            m_regs[k] = '0;
        end
        pc = RESET_PC;
        npc = pc + 4;
        for (int steps = 0; steps < 2000; steps++) begin
            exp_pc.push_back(pc);
            if (pc == RESET_PC + 4 * LOOP) begin
                break;
            end
            ins = prog[(pc - RESET_PC) >> 2];
            a = m_regs[ins[25:21]];
            b = m_regs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            ea = a + simm;
            nxt = npc + 4;
            wr = 1'b1;
            d = ins[20:16];
            res = '0;
            case (ins[31:26])
                6'h00: begin
                    d = ins[15:11];
                    case (ins[5:0])
                        6'h00: res = b << ins[10:6];
                        6'h02: res = b >> ins[10:6];
                        6'h03: res = word_t'($signed(b) >>> ins[10:6]);
                        6'h21: res = a + b;
                        6'h23: res = a - b;
                        6'h24: res = a & b;
                        6'h25: res = a | b;
                        6'h26: res = a ^ b;
                        6'h27: res = ~(a | b);
                        6'h2a: res = {31'd0, $signed(a) < $signed(b)};
                        6'h2b: res = {31'd0, a < b};
                        default: wr = 1'b0;
                    endcase
                end
                6'h02: begin
                    wr = 1'b0;
                    nxt = {npc[31:28], ins[25:0], 2'b00};
                end
                6'h03: begin
                    d = 5'd31;
                    res = pc + 8;
                    nxt = {npc[31:28], ins[25:0], 2'b00};
                end
                6'h04: begin
                    wr = 1'b0;
                    if (a == b) nxt = npc + (simm << 2);
                end
                6'h05: begin
                    wr = 1'b0;
                    if (a != b) nxt = npc + (simm << 2);
                end
                6'h09: res = a + simm;
                6'h0a: res = {31'd0, $signed(a) < $signed(simm)};
                6'h0c: res = a & {16'h0, ins[15:0]};
                6'h0d: res = a | {16'h0, ins[15:0]};
                6'h0e: res = a ^ {16'h0, ins[15:0]};
                6'h0f: res = {ins[15:0], 16'h0};
                6'h23: begin
                    res = m_mem[ea[7:2]];
                    exp_acc.push_back(dbus_req_t'{valid: 1'b1, addr: ea, strobe: 4'h0,
                                                  data: '0});
                end
                6'h2b: begin
                    wr = 1'b0;
                    m_mem[ea[7:2]] = b;
                    exp_acc.push_back(dbus_req_t'{valid: 1'b1, addr: ea, strobe: 4'hf,
                                                  data: b});
                end
                default: wr = 1'b0;
            endcase
            if (wr) m_regs[d] = res;
            m_regs[0] = '0;
            pc = npc;
            npc = nxt;
        end
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // instruction and data bus responders
    always @(posedge clk) begin
        int n;
        if (!resetn) begin
            iresp <= '0;
            dresp <= '0;
            i_left <= 0;
            d_left <= 0;
        end else begin
            if (iresp.data_ok) begin
                iresp.data_ok <= 1'b0;
                if (ireq.valid) got_pc.push_back(ireq.addr);
            end else if (ireq.valid) begin
                n = (i_left == 0) ? 1 + rand_bits(2) % 3 : i_left;
                if (n == 1) begin
                    iresp.data_ok <= 1'b1;
                    iresp.data <= ((ireq.addr - RESET_PC) >> 2 < 128) ?
                                  prog[(ireq.addr - RESET_PC) >> 2] : '0;
                end
                i_left <= n - 1;
            end
            if (dresp.data_ok) begin
                dresp.data_ok <= 1'b0;
                if (dreq.valid) begin
                    got_acc.push_back(dbus_req_t'{valid: 1'b1, addr: dreq.addr,
                                                  strobe: dreq.strobe,
                                                  data: (dreq.strobe == 4'hf) ? dreq.data : '0});
                end
            end else if (dreq.valid) begin
                n = (d_left == 0) ? 1 + rand_bits(2) % 3 : d_left;
                if (n == 1) begin
                    if (dreq.strobe == 4'hf) dmem[dreq.addr[7:2]] <= dreq.data;
                    dresp.data_ok <= 1'b1;
                    dresp.data <= dmem[dreq.addr[7:2]];
                end
                d_left <= n - 1;
            end
        end
    end

    initial begin
        int   cyc;
        addr_t loop_pc;
        lfsr = 32'h55ac;
        errors = 0;
        timeouts = 0;
        resetn = 1'b0;
        iresp = '0;
        dresp = '0;
        loop_pc = RESET_PC + 4 * LOOP;
        // prologue gives every register a known value
        for (int k = 0; k < PRO; k++) begin
            prog[k] = {6'h09, 5'd0, 5'(k + 1), 16'(rand_bits(16))};
        end
        for (int k = PRO; k < DUMP; k++) begin
            prog[k] = body_instr(k, !is_transfer(prog[k - 1]) && k < DUMP - 1);
        end
        for (int k = 1; k < 32; k++) begin
            prog[DUMP + k - 1] = {6'h2b, 5'd0, 5'(k), 16'(4 * k)};
        end
        prog[LOOP] = {6'h02, loop_pc[27:2]};
        for (int k = LOOP + 1; k < 128; k++) begin
            prog[k] = '0;
        end
        for (int k = 0; k < 64; k++) begin
            dmem[k] = rand_bits(32);
            m_mem[k] = dmem[k];
        end
        run_model();

        repeat (8) @(posedge clk);
        resetn <= 1'b1;

        for (cyc = 0; cyc < 20000; cyc++) begin
            if (got_acc.size() >= exp_acc.size() && got_pc.size() >= exp_pc.size()) break;
            @(posedge clk);
        end
        if (cyc >= 20000) begin
            timeouts++;
            $display("Timed out waiting for the program to reach its final loop");
        end else begin
            // let any duplicated access show up
            for (cyc = 0; cyc < 40; cyc++) @(posedge clk);
        end

        if (got_pc.size() > 0) check(got_pc[0], RESET_PC, "first fetch address");
        for (int k = 0; k < exp_pc.size() && k < got_pc.size(); k++) begin
            check(got_pc[k], exp_pc[k], $sformatf("fetch %0d address", k));
        end
        check(got_acc.size(), exp_acc.size(), "data access count");
        for (int k = 0; k < exp_acc.size() && k < got_acc.size(); k++) begin
            check(got_acc[k].addr, exp_acc[k].addr, $sformatf("access %0d address", k));
            check(got_acc[k].strobe, exp_acc[k].strobe, $sformatf("access %0d strobe", k));
            check(got_acc[k].data, exp_acc[k].data, $sformatf("access %0d store data", k));
        end

        $display("%0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
